//--- run_sim.sh
#!/usr/bin/env bash
# Builds the TLP transmit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f tlp_tx.f --top-module tlp_tx_tb -Mdir obj_dir -o tlp_tx_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/tlp_tx_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Verification passed" "$log_file"; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL"
    exit 1
fi

//--- source/axis_skid_buffer.sv
module axis_skid_buffer
    import tlp_stream_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  logic         in_valid,
    output logic         in_ready,
    input  stream_beat_t in_beat,

    output logic         out_valid,
    input  logic         out_ready,
    output stream_beat_t out_beat
);

    // Main register feeds the output, spare catches a beat during a stall
    logic         main_valid;
    stream_beat_t main_beat;
    logic         spare_valid;
    stream_beat_t spare_beat;

    logic in_fire;
    logic main_free;
    logic spare_load;
    logic spare_drain;

    assign in_fire = in_valid && in_ready;

    // Main can take a new beat when empty or when it drains this cycle
    assign main_free = !main_valid || out_ready;

    // A beat is parked only when main is stuck
    assign spare_load  = in_fire && !main_free;
    assign spare_drain = spare_valid && main_free;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
            in_ready    <= 1'b0;
        end
        else
        begin
            // The spare always has priority so beats leave in order
            if (main_free)
            begin
                main_valid <= spare_valid || in_fire;
            end
            spare_valid <= spare_load || (spare_valid && !spare_drain);
            // Keep accepting while the spare will be empty next cycle
            in_ready    <= !(spare_load || (spare_valid && !spare_drain));
        end
    end

    always_ff @(posedge clk)
    begin
        if (main_free)
        begin
            main_beat <= spare_valid ? spare_beat : in_beat;
        end
        if (spare_load)
        begin
            spare_beat <= in_beat;
        end
    end

    assign out_valid = main_valid;
    assign out_beat  = main_beat;

endmodule

//--- source/tlp_hdr_merge.sv
module tlp_hdr_merge
    import tlp_stream_pkg::*;
    import tlp_hdr_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    // Headers, one per TLP
    input  logic         hdr_valid,
    output logic         hdr_ready,
    input  hdr_beat_t    hdr,

    // Raw payload packed from lane 0
    input  logic         data_valid,
    output logic         data_ready,
    input  stream_beat_t data,

    // TLP stream with the header inline at byte 0
    output logic         out_valid,
    input  logic         out_ready,
    output stream_beat_t out
);

    // ============================================================
    // Packet tracking
    // ============================================================

    // Set while the next payload beat opens a new TLP
    logic is_sop;

    // Upper half of the previous payload beat still owed to the output
    logic                  carry_valid;
    logic [hdr_width-1:0]  carry_data;
    logic [hdr_bytes-1:0]  carry_keep;

    // Source of the TLP in flight, needed for the flush beat
    src_id_t cur_src;

    logic single_beat;
    logic out_fire;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            is_sop <= 1'b1;
        end
        else if (data_valid && data_ready)
        begin
            is_sop <= data.last;
        end
    end

    // The TLP fits in one beat when it has no data or the payload
    // does not spill past the space left after the header
    assign single_beat = !fmt_has_data(hdr.hdr.fmt_type) || !data.tkeep[tail_bytes];

    assign out_fire = out_valid && out_ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            carry_valid <= 1'b0;
        end
        else if (out_fire)
        begin
            if (data_ready)
            begin
                // Bytes spill over whenever the upper half of the beat is used
                carry_valid <= is_sop ? !single_beat : data.tkeep[tail_bytes];
            end
            else
            begin
                // A beat went out with no input, so that was the flush
                carry_valid <= 1'b0;
            end
        end
    end

    // The carry always shifts by exactly one header
    always_ff @(posedge clk)
    begin
        if (out_fire)
        begin
            carry_data <= data.tdata[tail_width +: hdr_width];
            carry_keep <= data.tkeep[tail_bytes +: hdr_bytes];
        end
        if (hdr_valid && hdr_ready)
        begin
            cur_src <= hdr.src;
        end
    end

    // ============================================================
    // Handshakes
    // ============================================================

    // Header and first payload beat go together, after any flush
    assign hdr_ready = hdr_valid && data_valid && out_ready && is_sop && !carry_valid;

    assign data_ready = data_valid && out_ready &&
                        (!is_sop || (hdr_valid && !carry_valid));

    // Output either carries new payload or flushes the final carry
    assign out_valid = data_ready || (is_sop && carry_valid);

    // ============================================================
    // Output beat
    // ============================================================

    always_comb
    begin
        if (hdr_ready)
        begin
            // Start of TLP: header in the low lanes, payload above it
            out.tdata = {data.tdata[0 +: tail_width], hdr.hdr};
            out.tkeep = {data.tkeep[0 +: tail_bytes], {hdr_bytes{1'b1}}};
            out.last  = single_beat;
            out.src   = hdr.src;
        end
        else
        begin
            out.tdata = {data.tdata[0 +: tail_width], carry_data};
            out.tkeep = {data.tkeep[0 +: tail_bytes], carry_keep};
            if (is_sop)
            begin
                // Flush beat, the input belongs to the next TLP
                out.tdata[hdr_width +: tail_width] = '0;
                out.tkeep[hdr_bytes +: tail_bytes] = '0;
            end
            // The beat ends the TLP if nothing spills into another carry
            out.last  = is_sop || !data.tkeep[tail_bytes];
            out.src   = cur_src;
        end
    end

endmodule

//--- source/tlp_hdr_pkg.sv
package tlp_hdr_pkg;

    import tlp_stream_pkg::*;

    // ============================================================
    // Header geometry
    // ============================================================

    // All headers handled here are the 4DW form
    localparam int hdr_width = 128;
    localparam int hdr_bytes = hdr_width / 8;

    // Room left in a beat once a header sits in its low lanes
    localparam int tail_width = data_width - hdr_width;
    localparam int tail_bytes = keep_width - hdr_bytes;

    // ============================================================
    // Header fields
    // ============================================================

    // Fmt and type packed together as in the first header byte
    typedef enum logic [7:0] {
        mem_rd = 8'h20,
        mem_wr = 8'h60,
        cpl    = 8'h0a,
        cpl_d  = 8'h4a
    } fmt_type_e;

    typedef logic [9:0]  length_dw_t;
    typedef logic [15:0] requester_id_t;
    typedef logic [7:0]  tag_t;

    // The fields used by this block, the rest is carried untouched
    typedef struct packed {
        fmt_type_e     fmt_type;
        length_dw_t    length_dw;
        requester_id_t requester_id;
        tag_t          tag;
        logic [85:0]   rsvd;
    } tlp_hdr_t;

    // A header as it leaves the arbiter, tagged with its source
    typedef struct packed {
        tlp_hdr_t hdr;
        src_id_t  src;
    } hdr_beat_t;

    // Writes and completions with data carry a payload, the rest do not
    function automatic logic fmt_has_data(fmt_type_e fmt);
        return (fmt == mem_wr) || (fmt == cpl_d);
    endfunction

endpackage

//--- source/tlp_source_arbiter.sv
module tlp_source_arbiter
    import tlp_stream_pkg::*;
    import tlp_hdr_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    // Request engine
    input  logic         req_hdr_valid,
    output logic         req_hdr_ready,
    input  tlp_hdr_t     req_hdr,
    input  logic         req_data_valid,
    output logic         req_data_ready,
    input  stream_beat_t req_data,

    // Completion engine
    input  logic         cpl_hdr_valid,
    output logic         cpl_hdr_ready,
    input  tlp_hdr_t     cpl_hdr,
    input  logic         cpl_data_valid,
    output logic         cpl_data_ready,
    input  stream_beat_t cpl_data,

    // Shared path towards the merge block
    output logic         hdr_valid,
    input  logic         hdr_ready,
    output hdr_beat_t    hdr,
    output logic         data_valid,
    input  logic         data_ready,
    output stream_beat_t data
);

    typedef enum logic {
        arb_idle,
        arb_locked
    } arb_state_e;

    arb_state_e state;
    src_id_t    grant;
    src_id_t    last_served;
    src_id_t    pick;
    src_id_t    sel;

    logic hdr_fire;
    logic eop_fire;

    // With both headers waiting the source not served last wins
    assign pick = (req_hdr_valid && cpl_hdr_valid) ? ~last_served : src_id_t'(cpl_hdr_valid);

    // While locked the stored grant steers the payload
    assign sel = (state == arb_locked) ? grant : pick;

    // Headers only pass while idle, a locked TLP has already sent its own
    assign hdr_valid = (state == arb_idle) && (sel[0] ? cpl_hdr_valid : req_hdr_valid);
    assign hdr.hdr   = sel[0] ? cpl_hdr : req_hdr;
    assign hdr.src   = sel;

    assign req_hdr_ready = (state == arb_idle) && hdr_ready && (sel == 1'b0);
    assign cpl_hdr_ready = (state == arb_idle) && hdr_ready && (sel == 1'b1);

    // Payload is stamped with the granted source
    assign data_valid     = sel[0] ? cpl_data_valid : req_data_valid;
    assign data.tdata     = sel[0] ? cpl_data.tdata : req_data.tdata;
    assign data.tkeep     = sel[0] ? cpl_data.tkeep : req_data.tkeep;
    assign data.last      = sel[0] ? cpl_data.last : req_data.last;
    assign data.src       = sel;
    assign req_data_ready = data_ready && (sel == 1'b0);
    assign cpl_data_ready = data_ready && (sel == 1'b1);

    assign hdr_fire = hdr_valid && hdr_ready;
    assign eop_fire = data_valid && data_ready && data.last;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state       <= arb_idle;
            grant       <= '0;
            last_served <= '1;
        end
        else
        begin
            case (state)
                arb_idle:
                begin
                    if (hdr_fire)
                    begin
                        grant       <= pick;
                        last_served <= pick;
                        // A single-beat TLP finishes in the cycle it starts
                        if (!eop_fire)
                        begin
                            state <= arb_locked;
                        end
                    end
                end
                arb_locked:
                begin
                    if (eop_fire)
                    begin
                        state <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

endmodule

//--- source/tlp_stream_pkg.sv
package tlp_stream_pkg;

    // ============================================================
    // Stream geometry
    // ============================================================

    // Width of one beat of the TLP stream in bits
    localparam int data_width = 256;

    // One keep bit per byte lane
    localparam int keep_width = data_width / 8;

    // ============================================================
    // Beat types
    // ============================================================

    // One beat of TLP bytes, byte 0 sits in bits [7:0]
    typedef logic [data_width-1:0] tdata_t;

    // Byte-lane keep mask; set lanes always run contiguously from lane 0
    typedef logic [keep_width-1:0] tkeep_t;

    // Source tag carried with every beat
    // Value 0 is the request engine and value 1 is the completion engine
    typedef logic [0:0] src_id_t;

    // A full stream beat as it travels on the payload inputs,
    // between the merge block and the skid buffer, and on the output
    typedef struct packed {
        tdata_t  tdata;
        tkeep_t  tkeep;
        logic    last;
        src_id_t src;
    } stream_beat_t;

endpackage

//--- source/tlp_tx_top.sv
module tlp_tx_top
    import tlp_stream_pkg::*;
    import tlp_hdr_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    // Request engine
    input  logic         req_hdr_valid,
    output logic         req_hdr_ready,
    input  tlp_hdr_t     req_hdr,
    input  logic         req_data_valid,
    output logic         req_data_ready,
    input  stream_beat_t req_data,

    // Completion engine
    input  logic         cpl_hdr_valid,
    output logic         cpl_hdr_ready,
    input  tlp_hdr_t     cpl_hdr,
    input  logic         cpl_data_valid,
    output logic         cpl_data_ready,
    input  stream_beat_t cpl_data,

    // Registered TLP output
    output logic         tlp_valid,
    input  logic         tlp_ready,
    output stream_beat_t tlp
);

    // Arbiter to merge
    logic         hdr_valid;
    logic         hdr_ready;
    hdr_beat_t    hdr;
    logic         data_valid;
    logic         data_ready;
    stream_beat_t data;

    // Merge to output buffer
    logic         mrg_valid;
    logic         mrg_ready;
    stream_beat_t mrg_beat;

    tlp_source_arbiter u_arbiter (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_hdr_valid  (req_hdr_valid),
        .req_hdr_ready  (req_hdr_ready),
        .req_hdr        (req_hdr),
        .req_data_valid (req_data_valid),
        .req_data_ready (req_data_ready),
        .req_data       (req_data),
        .cpl_hdr_valid  (cpl_hdr_valid),
        .cpl_hdr_ready  (cpl_hdr_ready),
        .cpl_hdr        (cpl_hdr),
        .cpl_data_valid (cpl_data_valid),
        .cpl_data_ready (cpl_data_ready),
        .cpl_data       (cpl_data),
        .hdr_valid      (hdr_valid),
        .hdr_ready      (hdr_ready),
        .hdr            (hdr),
        .data_valid     (data_valid),
        .data_ready     (data_ready),
        .data           (data)
    );

    tlp_hdr_merge u_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .hdr_valid  (hdr_valid),
        .hdr_ready  (hdr_ready),
        .hdr        (hdr),
        .data_valid (data_valid),
        .data_ready (data_ready),
        .data       (data),
        .out_valid  (mrg_valid),
        .out_ready  (mrg_ready),
        .out        (mrg_beat)
    );

    // Registers the output and cuts the ready path back into the merge
    axis_skid_buffer u_out_skid (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (mrg_valid),
        .in_ready  (mrg_ready),
        .in_beat   (mrg_beat),
        .out_valid (tlp_valid),
        .out_ready (tlp_ready),
        .out_beat  (tlp)
    );

endmodule

//--- tb/tlp_tx_checker.sv
module tlp_tx_checker
    import tlp_stream_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input logic         tlp_valid,
    input logic         tlp_ready,
    input stream_beat_t tlp,
    input logic         req_hdr_ready,
    input logic         cpl_hdr_ready
);

    // Running count of protocol violations seen on the output and the arbiter
    int assert_fails = 0;

    // ============================================================
    // Output stream rules
    // ============================================================

    // The output register comes out of reset empty
    reset_empty: assert property (@(posedge clk) !rst_n |=> !tlp_valid)
    else
    begin
        assert_fails++;
        $error("tlp_valid is high right after reset");
    end

    // A stalled beat must hold still until it is taken
    stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (tlp_valid && !tlp_ready) |=> (tlp_valid && $stable(tlp)))
    else
    begin
        assert_fails++;
        $error("output beat changed while tlp_ready was low");
    end

    // Kept lanes form one run from lane 0, so keep plus one shares no bit with keep
    keep_contig: assert property (@(posedge clk) disable iff (!rst_n)
        tlp_valid |-> ((tlp.tkeep & tkeep_t'(tlp.tkeep + 1'b1)) == '0))
    else
    begin
        assert_fails++;
        $error("output tkeep is not contiguous from lane 0");
    end

    // Only one source may be handed the header path at a time
    one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(req_hdr_ready && cpl_hdr_ready))
    else
    begin
        assert_fails++;
        $error("both header readys are high together");
    end

endmodule

bind tlp_tx_top tlp_tx_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .tlp_valid     (tlp_valid),
    .tlp_ready     (tlp_ready),
    .tlp           (tlp),
    .req_hdr_ready (req_hdr_ready),
    .cpl_hdr_ready (cpl_hdr_ready)
);

//--- tb/tlp_tx_tb.sv
module tlp_tx_tb
    import tlp_stream_pkg::*;
    import tlp_hdr_pkg::*;
();

    // Longest payload used anywhere is 32 DW
    localparam int max_pay = 128;
    // About 95 TLPs of up to five beats, stretched by gaps and output stalls
    localparam int max_cycles = 4000;

    typedef logic [7:0] pay_t [max_pay];

    logic clk;
    logic rst_n;

    // Index 0 is the request engine and index 1 the completion engine
    logic [1:0]   hdr_valid_v;
    logic [1:0]   hdr_ready_v;
    tlp_hdr_t     hdr_s [2];
    logic [1:0]   data_valid_v;
    logic [1:0]   data_ready_v;
    stream_beat_t data_s [2];

    logic         tlp_valid;
    logic         tlp_ready;
    stream_beat_t tlp;

    // Expected output beats per source, oldest first
    stream_beat_t exp_req [$];
    stream_beat_t exp_cpl [$];

    int      errors;
    int      errors_at_start;
    int      tests_run;
    int      tests_failed;
    int      cycles;
    int      tag_n;
    logic    ready_random;
    logic    mid_tlp;
    src_id_t mid_src;

    tlp_tx_top UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_hdr_valid  (hdr_valid_v[0]),
        .req_hdr_ready  (hdr_ready_v[0]),
        .req_hdr        (hdr_s[0]),
        .req_data_valid (data_valid_v[0]),
        .req_data_ready (data_ready_v[0]),
        .req_data       (data_s[0]),
        .cpl_hdr_valid  (hdr_valid_v[1]),
        .cpl_hdr_ready  (hdr_ready_v[1]),
        .cpl_hdr        (hdr_s[1]),
        .cpl_data_valid (data_valid_v[1]),
        .cpl_data_ready (data_ready_v[1]),
        .cpl_data       (data_s[1]),
        .tlp_valid      (tlp_valid),
        .tlp_ready      (tlp_ready),
        .tlp            (tlp)
    );

    // ============================================================
    // Clock, watchdog and output ready
    // ============================================================

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles)
        begin
            $display("Run stopped after %0d cycles with traffic still pending", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // Output ready is held high unless a test asks for random stalls
    always @(posedge clk)
    begin
        if (ready_random)
            tlp_ready <= ($urandom_range(3, 0) != 0);
        else
            tlp_ready <= 1'b1;
    end

    // ============================================================
    // Reference model and checks
    // ============================================================

    // Header bytes then payload bytes, cut into 32-byte beats
    function automatic void build_expected(input tlp_hdr_t h, input pay_t pay,
                                           input int len, input int s);
        logic [7:0]   bytes [max_pay + hdr_bytes];
        stream_beat_t b;
        int           total;
        int           nbeats;
        total  = hdr_bytes + len;
        nbeats = (total + keep_width - 1) / keep_width;
        for (int i = 0; i < hdr_bytes; i++)
            bytes[i] = h[8*i +: 8];
        for (int i = 0; i < len; i++)
            bytes[hdr_bytes + i] = pay[i];
        for (int k = 0; k < nbeats; k++)
        begin
            b      = '0;
            b.src  = src_id_t'(s);
            b.last = (k == nbeats - 1);
            for (int j = 0; j < keep_width; j++)
            begin
                if (keep_width * k + j < total)
                begin
                    b.tdata[8*j +: 8] = bytes[keep_width * k + j];
                    b.tkeep[j]        = 1'b1;
                end
            end
            if (s == 0)
                exp_req.push_back(b);
            else
                exp_cpl.push_back(b);
        end
    endfunction

    task automatic check_value(input logic [255:0] got, input logic [255:0] exp,
                               input string what);
        if (got !== exp)
        begin
            errors++;
            $display("FAILED at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic compare_beat(input stream_beat_t got);
        stream_beat_t exp;
        tdata_t       mask;
        logic         empty;
        // A beat from the other source in the middle of a TLP means interleaving
        if (mid_tlp)
            check_value(256'(got.src), 256'(mid_src), "src of a beat inside an open TLP");
        mid_tlp = !got.last;
        mid_src = got.src;
        empty   = (got.src == 0) ? (exp_req.size() == 0) : (exp_cpl.size() == 0);
        if (empty)
        begin
            errors++;
            $display("An output beat from source %0d came with no TLP expected", got.src);
        end
        else
        begin
            if (got.src == 0)
                exp = exp_req.pop_front();
            else
                exp = exp_cpl.pop_front();
            mask = '0;
            for (int j = 0; j < keep_width; j++)
                if (exp.tkeep[j])
                    mask[8*j +: 8] = 8'hff;
            check_value(got.tdata & mask, exp.tdata & mask, "tdata");
            check_value(256'(got.tkeep), 256'(exp.tkeep), "tkeep");
            check_value(256'(got.last), 256'(exp.last), "last");
            check_value(256'(got.src), 256'(exp.src), "src");
        end
    endtask

    // Ready and valid are settled at the falling edge, the transfer follows
    always @(negedge clk)
    begin
        if (rst_n && tlp_valid && tlp_ready)
            compare_beat(tlp);
    end

    // ============================================================
    // Source drivers
    // ============================================================

    task automatic send_tlp(input int s, input fmt_type_e fmt, input int len);
        tlp_hdr_t     h;
        pay_t         pay;
        stream_beat_t b;
        int           nbeats;
        h              = '0;
        h.fmt_type     = fmt;
        h.length_dw    = 10'(len / 4);
        h.requester_id = (s == 0) ? 16'h0100 : 16'h0200;
        h.tag          = 8'(tag_n);
        h.rsvd         = 86'({$urandom(), $urandom(), $urandom()});
        tag_n++;
        for (int i = 0; i < max_pay; i++)
            pay[i] = (i < len) ? 8'($urandom()) : 8'h00;
        build_expected(h, pay, len, s);
        // A TLP without data still sends one empty last beat
        nbeats = (len == 0) ? 1 : (len + keep_width - 1) / keep_width;
        @(posedge clk);
        fork
            begin
                hdr_s[s]       <= h;
                hdr_valid_v[s] <= 1'b1;
                do @(negedge clk); while (!hdr_ready_v[s]);
                @(posedge clk);
                hdr_valid_v[s] <= 1'b0;
            end
            begin
                for (int k = 0; k < nbeats; k++)
                begin
                    b      = '0;
                    b.src  = src_id_t'(s);
                    b.last = (k == nbeats - 1);
                    for (int j = 0; j < keep_width; j++)
                    begin
                        if (keep_width * k + j < len)
                        begin
                            b.tdata[8*j +: 8] = pay[keep_width * k + j];
                            b.tkeep[j]        = 1'b1;
                        end
                    end
                    data_s[s]       <= b;
                    data_valid_v[s] <= 1'b1;
                    do @(negedge clk); while (!data_ready_v[s]);
                    @(posedge clk);
                end
                data_valid_v[s] <= 1'b0;
            end
        join
    endtask

    // Random length in whole DW, with a quarter of the TLPs carrying no data
    task automatic send_random(input int s);
        int        len;
        fmt_type_e fmt;
        if ($urandom_range(3, 0) == 0)
            len = 0;
        else
            len = 4 * int'($urandom_range(32, 1));
        if (s == 0)
            fmt = (len == 0) ? mem_rd : mem_wr;
        else
            fmt = (len == 0) ? cpl : cpl_d;
        repeat ($urandom_range(2, 0)) @(posedge clk);
        send_tlp(s, fmt, len);
    endtask

    // Waits for the expected lists to drain and reports the test
    task automatic end_test(input string name);
        int waited;
        waited = 0;
        while ((exp_req.size() + exp_cpl.size()) != 0 && waited < 200)
        begin
            @(posedge clk);
            waited++;
        end
        if ((exp_req.size() + exp_cpl.size()) != 0)
        begin
            errors++;
            $display("%s: expected TLPs never appeared", name);
            exp_req.delete();
            exp_cpl.delete();
        end
        tests_run++;
        if (errors != errors_at_start)
            tests_failed++;
        $display("%s: %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial
    begin
        void'($urandom(32'ha348));
        rst_n           = 1'b0;
        hdr_valid_v     = '0;
        data_valid_v    = '0;
        hdr_s[0]        = '0;
        hdr_s[1]        = '0;
        data_s[0]       = '0;
        data_s[1]       = '0;
        tlp_ready       = 1'b0;
        ready_random    = 1'b0;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        cycles          = 0;
        tag_n           = 0;
        mid_tlp         = 1'b0;
        mid_src         = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        for (int i = 0; i < 4; i++)
            send_tlp(0, mem_rd, 0);
        end_test("test 1 reads without data");

        // Only the 20-byte write spills past its last payload beat into an extra final beat
        send_tlp(0, mem_wr, 4);
        send_tlp(0, mem_wr, 16);
        send_tlp(0, mem_wr, 20);
        send_tlp(0, mem_wr, 48);
        send_tlp(0, mem_wr, 112);
        end_test("test 2 writes of several lengths");

        fork
            repeat (20) send_random(0);
            repeat (20) send_random(1);
        join
        end_test("test 3 both sources at once");

        ready_random <= 1'b1;
        fork
            repeat (20) send_random(0);
            repeat (20) send_random(1);
        join
        end_test("test 4 both sources with output stalls");
        ready_random <= 1'b0;

        send_tlp(1, cpl, 0);
        send_tlp(1, cpl_d, 8);
        send_tlp(1, cpl, 0);
        send_tlp(1, cpl_d, 36);
        send_tlp(1, cpl, 0);
        send_tlp(1, cpl_d, 128);
        end_test("test 5 completions alone");

        errors = errors + UUT.u_checker.assert_fails;
        $display("Tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, UUT.u_checker.assert_fails);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- tlp_tx.f
source/tlp_stream_pkg.sv
source/tlp_hdr_pkg.sv
source/axis_skid_buffer.sv
source/tlp_source_arbiter.sv
source/tlp_hdr_merge.sv
source/tlp_tx_top.sv
tb/tlp_tx_checker.sv
tb/tlp_tx_tb.sv
